//--- Bender.yml
package:
  name: clampUnit

sources:
  - files:
      - common/clampPkg.sv
  - files:
      - arith/prefixAndOr.sv
      - arith/cmpGe.sv
  - files:
      - source/clampDatapath.sv
      - source/reqAckCtrl.sv
      - source/clampUnit.sv
  - target: simulation
    files:
      - sim/clampUnitTb.sv

//--- arith/cmpGe.sv
`timescale 1ns/100ps
`default_nettype none

// unsigned a >= b via a carry chain on a - b
module cmpGe #(
	parameter int width = 8, // word width
	parameter int speed = 1  // prefix structure
) (
	input  logic [width-1:0] a,  // operands
	input  logic [width-1:0] b,
	output logic             ge  // a >= b
);

	logic [width-1:0] gi; // prefix gen. in
	logic [width-1:0] pi; // prefix prop. in
	logic [width-1:0] go; // prefix gen. out

	// bit 0 carries the +1 of the two's complement so equal counts as generate
	assign gi[0] = a[0] | ~b[0];
	assign pi[0] = ~(a[0] ^ b[0]);

	for (genvar i = 1; i < width; i++) begin : preproc
		assign gi[i] = a[i] & ~b[i];    // a bit wins here
		assign pi[i] = ~(a[i] ^ b[i]);  // equal bits pass decision on
	end

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix (
		.GI(gi),
		.PI(pi),
		.GO(go),
		.PO()
	);

	assign ge = go[width-1]; // carry out of the top bit

endmodule

`default_nettype wire

//--- arith/prefixAndOr.sv
`timescale 1ns/100ps
`default_nettype none

module prefixAndOr #(
	parameter int width = 8, // word width
	parameter int speed = 1  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] GI, // gen. in
	input  logic [width-1:0] PI, // prop. in
	output logic [width-1:0] GO, // prefix gen. out
	output logic [width-1:0] PO  // prefix prop. out
);

	localparam int n = width;          // structure width
	localparam int m = $clog2(width);  // tree depth

	if (speed == 2) begin : fastPrefix
		// sklansky tree, m levels, fan-out doubles per level
		logic [n-1:0] gt [0:m]; // gen. per level
		logic [n-1:0] pt [0:m]; // prop. per level

		assign gt[0] = GI;
		assign pt[0] = PI;

		for (genvar l = 1; l <= m; l++) begin : levels
			localparam int half = 2**(l-1); // half group size
			for (genvar i = 0; i < n; i++) begin : bits
				// upper half of each group takes last bit of lower half
				localparam int src = ((i >> l) << l) + half - 1;
				if (((i >> (l-1)) % 2) == 1) begin : black
					assign gt[l][i] = gt[l-1][i] | (pt[l-1][i] & gt[l-1][src]);
					assign pt[l][i] = pt[l-1][i] & pt[l-1][src];
				end else begin : white
					assign gt[l][i] = gt[l-1][i]; // pass through
					assign pt[l][i] = pt[l-1][i];
				end
			end
		end

		assign GO = gt[m];
		assign PO = pt[m];

	end else if (speed == 1) begin : mediumPrefix
		// brent-kung, up-sweep of m levels then down-sweep of m-1
		localparam int stages = (m > 0) ? 2*m - 1 : 0;

		logic [n-1:0] gt [0:stages];
		logic [n-1:0] pt [0:stages];

		assign gt[0] = GI;
		assign pt[0] = PI;

		for (genvar s = 1; s <= stages; s++) begin : levels
			// tree level this stage works on
			localparam int l    = (s <= m) ? s : 2*m - s;
			localparam int span = 2**(l-1); // distance to partner node
			for (genvar i = 0; i < n; i++) begin : bits
				// up-sweep nodes close a group of 2**l bits
				localparam bit up   = (s <= m) && (((i + 1) % (2**l)) == 0);
				// down-sweep fills the middle of each group from the left neighbour
				localparam bit down = (s > m) && (((i + 1) % (2**l)) == span)
					&& (i >= 2**l);
				if (up || down) begin : black
					assign gt[s][i] = gt[s-1][i] | (pt[s-1][i] & gt[s-1][i-span]);
					assign pt[s][i] = pt[s-1][i] & pt[s-1][i-span];
				end else begin : white
					assign gt[s][i] = gt[s-1][i];
					assign pt[s][i] = pt[s-1][i];
				end
			end
		end

		assign GO = gt[stages];
		assign PO = pt[stages];

	end else begin : slowPrefix
		// serial chain, width-1 levels of and-or
		logic [n-1:0] gt; // gen. chain
		logic [n-1:0] pt; // prop. chain

		assign gt[0] = GI[0];
		assign pt[0] = PI[0];

		for (genvar i = 1; i < n; i++) begin : bits
			assign gt[i] = GI[i] | (PI[i] & gt[i-1]);
			assign pt[i] = PI[i] & pt[i-1];
		end

		assign GO = gt;
		assign PO = pt;
	end

endmodule

`default_nettype wire

//--- common/clampPkg.sv
`default_nettype none

package clampPkg;

	// command opcodes, encoding matches the stimulus file (0 to 3)
	typedef enum logic [1:0] {
		opSetLow   = 2'd0, // load lower bound
		opSetHigh  = 2'd1, // load upper bound
		opClamp    = 2'd2, // clamp data to bounds
		opTrackMax = 2'd3  // update running max
	} clampOp;

	// handshake controller states
	typedef enum logic [1:0] {
		stIdle    = 2'd0, // wait for req
		stCapture = 2'd1, // one-cycle capture strobe
		stAck     = 2'd2  // ack held until req drops
	} ctrlState;

endpackage

`default_nettype wire

//--- sim/clampStimulus.txt
// columns are op data result belowLow aboveHigh in hex
// op 0 setLow 1 setHigh 2 clamp 3 trackMax
2 5a 5a 0 0
// bounds 20 to c0
0 20 20 0 0
1 c0 c0 0 0
2 10 20 1 0
2 1f 20 1 0
2 20 20 0 0
2 21 21 0 0
2 80 80 0 0
2 bf bf 0 0
2 c0 c0 0 0
2 c1 c0 0 1
2 f0 c0 0 1
// comparator edges
0 ff ff 0 0
1 ff ff 0 0
2 00 ff 1 0
2 ff ff 0 0
2 7f ff 1 0
2 fe ff 1 0
0 00 00 0 0
1 00 00 0 0
2 ff 00 0 1
2 00 00 0 0
2 80 00 0 1
2 01 00 0 1
0 80 80 0 0
1 80 80 0 0
2 00 80 1 0
2 80 80 0 0
2 81 80 0 1
2 7f 80 1 0
// running maximum
3 10 10 0 0
3 40 40 0 0
3 90 90 0 0
3 80 90 0 0
3 20 90 0 0
3 90 90 0 0
3 90 90 0 0
3 ff ff 0 0
3 00 ff 0 0
// crossed bounds, low a0 above high 50
0 a0 a0 0 0
1 50 50 0 0
2 10 a0 1 0
2 9f a0 1 0
2 a0 50 0 1
2 f0 50 0 1
// open window again
0 00 00 0 0
1 ff ff 0 0
2 5a 5a 0 0

//--- sim/clampUnitTb.sv
`timescale 1ns/100ps
`default_nettype none

module clampUnitTb;

	localparam int width = 8;
	localparam int speed = 1; // 0 and 2 run the same vectors

	logic             clk;
	logic             rstN;
	logic             req;
	clampPkg::clampOp op;
	logic [width-1:0] data;
	logic             ack;
	logic [width-1:0] result;
	logic             belowLow;
	logic             aboveHigh;

	// vectors from the stimulus file
	logic [1:0]       opQ [$];
	logic [width-1:0] dataQ [$];
	logic [width-1:0] resQ [$];
	logic             belowQ [$];
	logic             aboveQ [$];

	int cycles;     // clock edges since start
	int cycleLimit; // 0 until vectors are loaded

	clampUnit #(
		.width(width),
		.speed(speed)
	) dut_i (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.op(op),
		.data(data),
		.ack(ack),
		.result(result),
		.belowLow(belowLow),
		.aboveHigh(aboveHigh)
	);

	always #20 clk = ~clk; // 40 ns period

	task automatic stopOnFailure;
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	// watchdog for a handshake that never completes
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout, the run did not finish within %0d cycles", cycleLimit);
			stopOnFailure();
		end
	end

	task automatic loadVectors;
		int          fd;
		int          n;
		int          badLines;
		string       line;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		badLines = 0;
		fd = $fopen("sim/clampStimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file sim/clampStimulus.txt");
			stopOnFailure();
		end else begin
			while ($fgets(line, fd) > 0) begin
				// skip comments and blank lines
				if (line.len() >= 3 && line.substr(0, 1) != "//") begin
					n = $sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4);
					if (n == 5) begin
						opQ.push_back(f0[1:0]);
						dataQ.push_back(f1[width-1:0]);
						resQ.push_back(f2[width-1:0]);
						belowQ.push_back(f3[0]);
						aboveQ.push_back(f4[0]);
					end else
						badLines++;
				end
			end
			$fclose(fd);
			if (badLines > 0) begin
				$display("the stimulus file has %0d lines that could not be read", badLines);
				stopOnFailure();
			end else if (opQ.size() == 0) begin
				$display("the stimulus file holds no vectors");
				stopOnFailure();
			end
		end
	endtask

	// one full four-phase handshake with req held idx % 4 extra cycles
	task automatic runCommand(input int idx);
		int               hold;
		logic [width-1:0] heldResult;
		hold = idx % 4;
		@(posedge clk);
		req  <= 1'b1;
		op   <= clampPkg::clampOp'(opQ[idx]);
		data <= dataQ[idx];
		@(negedge clk);
		while (!ack)
			@(negedge clk); // watchdog guards this
		assert (result === resQ[idx]) else begin
			$display("ERROR at %0t ns: vector %0d result %h, expected %h",
				$time, idx, result, resQ[idx]);
			stopOnFailure();
		end
		assert (belowLow === belowQ[idx]) else begin
			$display("ERROR at %0t ns: vector %0d belowLow %b, expected %b",
				$time, idx, belowLow, belowQ[idx]);
			stopOnFailure();
		end
		assert (aboveHigh === aboveQ[idx]) else begin
			$display("ERROR at %0t ns: vector %0d aboveHigh %b, expected %b",
				$time, idx, aboveHigh, aboveQ[idx]);
			stopOnFailure();
		end
		heldResult = result;
		repeat (hold) begin
			@(negedge clk);
			assert (ack === 1'b1) else begin
				$display("ERROR at %0t ns: vector %0d ack dropped while req held", $time, idx);
				stopOnFailure();
			end
			assert (result === heldResult) else begin
				$display("ERROR at %0t ns: vector %0d result changed to %h while req held",
					$time, idx, result);
				stopOnFailure();
			end
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		while (ack)
			@(negedge clk); // ack must fall before next req
	endtask

	initial begin
		clk        = 1'b0;
		rstN       = 1'b0;
		req        = 1'b0;
		op         = clampPkg::opSetLow;
		data       = '0;
		cycles     = 0;
		cycleLimit = 0;
		loadVectors();
		cycleLimit = 20 * opQ.size() + 50;
		repeat (3) @(posedge clk);
		rstN <= 1'b1;
		@(negedge clk);
		assert (ack === 1'b0) else begin
			$display("ERROR at %0t ns: ack high right after reset", $time);
			stopOnFailure();
		end
		for (int i = 0; i < opQ.size(); i++)
			runCommand(i);
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/clampDatapath.sv
`timescale 1ns/100ps
`default_nettype none

module clampDatapath #(
	parameter int width = 8, // word width
	parameter int speed = 1  // comparator prefix structure
) (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  capture,   // one-cycle strobe from controller
	input  clampPkg::clampOp      op,
	input  logic [width-1:0]      data,
	output logic [width-1:0]      result,
	output logic                  belowLow,
	output logic                  aboveHigh
);

	logic [width-1:0] lowBound;  // lower clamp bound
	logic [width-1:0] highBound; // upper clamp bound
	logic [width-1:0] runMax;    // running maximum
	logic             geLow;     // data >= low
	logic             geHigh;    // high >= data
	logic             geMax;     // data >= max

	logic [width-1:0] resultNxt;
	logic             belowNxt;
	logic             aboveNxt;

	cmpGe #(.width(width), .speed(speed)) lowCmp  (.a(data),      .b(lowBound), .ge(geLow));
	cmpGe #(.width(width), .speed(speed)) highCmp (.a(highBound), .b(data),     .ge(geHigh));
	cmpGe #(.width(width), .speed(speed)) maxCmp  (.a(data),      .b(runMax),   .ge(geMax));

	// outcome of the current command
	always_comb begin
		resultNxt = data; // set ops echo data
		belowNxt  = 1'b0;
		aboveNxt  = 1'b0;
		case (op)
			clampPkg::opClamp: begin
				// low test first, so crossed bounds give low
				if (!geLow) begin
					resultNxt = lowBound;
					belowNxt  = 1'b1;
				end else if (!geHigh) begin
					resultNxt = highBound;
					aboveNxt  = 1'b1;
				end
			end
			clampPkg::opTrackMax: resultNxt = geMax ? data : runMax; // new max
			default: resultNxt = data;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lowBound  <= '0;
			highBound <= '1; // open window until bounds are set
			runMax    <= '0;
			result    <= '0;
			belowLow  <= 1'b0;
			aboveHigh <= 1'b0;
		end else if (capture) begin
			result    <= resultNxt;
			belowLow  <= belowNxt;
			aboveHigh <= aboveNxt;
			if (op == clampPkg::opSetLow)
				lowBound <= data;
			if (op == clampPkg::opSetHigh)
				highBound <= data;
			if (op == clampPkg::opTrackMax && geMax)
				runMax <= data; // never decreases
		end
	end

endmodule

`default_nettype wire

//--- source/clampUnit.sv
`timescale 1ns/100ps
`default_nettype none

// bounded-value unit, one command per req/ack cycle
module clampUnit #(
	parameter int width = 8, // word width
	parameter int speed = 1  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic             clk,
	input  logic             rstN,
	input  logic             req,
	input  clampPkg::clampOp op,       // stable while req high
	input  logic [width-1:0] data,     // stable while req high
	output logic             ack,
	output logic [width-1:0] result,   // held until next capture
	output logic             belowLow, // clamp hit lower bound
	output logic             aboveHigh // clamp hit upper bound
);

	logic capture; // controller to datapath

	// handshake side
	reqAckCtrl ctrl (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.capture(capture),
		.ack(ack)
	);

	// bounds, max and result registers
	clampDatapath #(
		.width(width),
		.speed(speed)
	) datapath (
		.clk(clk),
		.rstN(rstN),
		.capture(capture),
		.op(op),
		.data(data),
		.result(result),
		.belowLow(belowLow),
		.aboveHigh(aboveHigh)
	);

endmodule

`default_nettype wire

//--- source/reqAckCtrl.sv
`timescale 1ns/100ps
`default_nettype none

// four-phase req/ack slave side
module reqAckCtrl (
	input  logic clk,
	input  logic rstN,
	input  logic req,     // from requester
	output logic capture, // datapath load strobe
	output logic ack      // to requester
);

	clampPkg::ctrlState state;
	clampPkg::ctrlState stateNxt;

	always_comb begin
		stateNxt = state;
		case (state)
			clampPkg::stIdle: begin
				if (req)
					stateNxt = clampPkg::stCapture; // op and data are stable now
			end
			clampPkg::stCapture: stateNxt = clampPkg::stAck; // single cycle
			clampPkg::stAck: begin
				// req is only looked at again once low, so a held req captures nothing
				if (!req)
					stateNxt = clampPkg::stIdle;
			end
			default: stateNxt = clampPkg::stIdle; // unused encoding
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= clampPkg::stIdle;
		else
			state <= stateNxt;
	end

	// strobe decoded from the state register, high for one cycle
	assign capture = (state == clampPkg::stCapture);

	// ack from its own flop, glitch free for an outside requester
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			ack <= 1'b0;
		else
			ack <= (stateNxt == clampPkg::stAck);
	end

endmodule

`default_nettype wire

//--- vlog.f
common/clampPkg.sv
arith/prefixAndOr.sv
arith/cmpGe.sv
source/clampDatapath.sv
source/reqAckCtrl.sv
source/clampUnit.sv
sim/clampUnitTb.sv
